// File: src/video_pkg.sv
package video_pkg;

   // ----------------------------------------------------------
   // pixel format
   // ----------------------------------------------------------

   // one rgb pixel as delivered by the debayer stage
   // red in the upper byte and blue in the lower byte
   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } pix_t;

   // ----------------------------------------------------------
   // camera line tracking
   // ----------------------------------------------------------

   // width of the line counter in the csi domain
   localparam int line_cnt_w = 11;

   // counter stops here so a runaway sensor cannot wrap it
   localparam logic [line_cnt_w-1:0] line_cnt_max = line_cnt_w'(1300);

   // rgb output needs three lines of history before it is valid
   // the debayer window is three lines tall
   localparam logic [line_cnt_w-1:0] rgb_valid_line = line_cnt_w'(3);

   // hdmi side is held in reset between frame start
   // and the first line edge of the camera
   localparam logic [line_cnt_w-1:0] hdmi_release_line = line_cnt_w'(1);

endpackage : video_pkg

// File: src/cdc_pkg.sv
package cdc_pkg;

   // ----------------------------------------------------------
   // line fifo geometry
   // ----------------------------------------------------------

   // number of entries, must stay a power of two
   // so the gray pointers wrap cleanly
   localparam int fifo_depth = 16;

   // address bits plus one wrap bit for full/empty
   localparam int fifo_ptr_w = $clog2(fifo_depth) + 1;

   // ----------------------------------------------------------
   // debug bus layout
   // ----------------------------------------------------------

   localparam int debug_w = 4;

   // read side view of the write pointer meeting the read pointer
   localparam int dbg_full = 0;
   // nothing left to pop
   localparam int dbg_empty = 1;
   // sticky, a camera write was lost
   localparam int dbg_overflow = 2;
   // sticky, display asked for a pixel that was not there
   localparam int dbg_underflow = 3;

endpackage : cdc_pkg

// File: src/frame_line_tracker.sv
`timescale 1ns/1ps

module frame_line_tracker (
   input  logic csi_clk,
   input  logic reset,
   input  logic csi_in_frame,
   input  logic csi_in_line,
   output logic rgb_valid,
   output logic hdmi_reset_n,
   output logic fifo_flush
);

   // strobe values from the previous edge
   logic frame_dly;
   logic line_dly;

   // single cycle start markers
   logic frame_rise;
   logic line_rise;

   // lines seen since the last frame start
   logic [video_pkg::line_cnt_w-1:0] line_cnt;

   // ----------------------------------------------------------
   // strobe edge detection
   // ----------------------------------------------------------

   // strobe high at this edge and low at the one before
   assign frame_rise = csi_in_frame & ~frame_dly;
   assign line_rise  = csi_in_line & ~line_dly;

   always_ff @(posedge csi_clk) begin
      if (reset) begin
         frame_dly <= 1'b0;
         line_dly  <= 1'b0;
      end else begin
         frame_dly <= csi_in_frame;
         line_dly  <= csi_in_line;
      end
   end

   // ----------------------------------------------------------
   // saturating line counter
   // ----------------------------------------------------------

   always_ff @(posedge csi_clk) begin
      if (reset) begin
         line_cnt <= '0;
      end else if (frame_rise) begin
         // new frame restarts the count
         line_cnt <= '0;
      end else if (line_rise && (line_cnt < video_pkg::line_cnt_max)) begin
         line_cnt <= line_cnt + 1'b1;
      end
   end

   // ----------------------------------------------------------
   // status towards rgb and hdmi
   // ----------------------------------------------------------

   // both follow the count one edge later
   always_ff @(posedge csi_clk) begin
      if (reset) begin
         rgb_valid    <= 1'b0;
         hdmi_reset_n <= 1'b0;
      end else begin
         // debayer window is filled from this line on
         rgb_valid    <= (line_cnt >= video_pkg::rgb_valid_line);
         // release display once the camera has started a line
         hdmi_reset_n <= (line_cnt >= video_pkg::hdmi_release_line);
      end
   end

   // fifo flush
   // held through reset and pulsed once per frame start
   always_ff @(posedge csi_clk) begin
      if (reset) begin
         fifo_flush <= 1'b1;
      end else begin
         fifo_flush <= frame_rise;
      end
   end

   // ----------------------------------------------------------
   // checks
   // ----------------------------------------------------------

   // count never passes the saturation limit over any frame
   a_cnt_sat : assert property (@(posedge csi_clk) disable iff (reset)
      line_cnt <= video_pkg::line_cnt_max);

   // frame flush is a one cycle pulse once reset is over
   a_flush_pulse : assert property (@(posedge csi_clk) disable iff (reset)
      (fifo_flush && !$past(reset)) |=> !fifo_flush);

endmodule : frame_line_tracker

// File: src/async_line_fifo.sv
`timescale 1ns/1ps

module async_line_fifo #(
   parameter type payload_t = logic [23:0]
) (
   input  logic                        wr_clk,
   input  logic                        wr_flush,
   input  logic                        wr_en,
   input  payload_t                    wr_data,
   input  logic                        rd_clk,
   input  logic                        rd_frame,
   input  logic                        rd_blank,
   output payload_t                    rd_data,
   output logic                        rd_valid,
   output logic [cdc_pkg::debug_w-1:0] debug
);

   // shared storage
   payload_t mem [cdc_pkg::fifo_depth];

   // write domain state
   logic [cdc_pkg::fifo_ptr_w-1:0] wr_bin;
   logic [cdc_pkg::fifo_ptr_w-1:0] wr_bin_nxt;
   logic [cdc_pkg::fifo_ptr_w-1:0] wr_gray;
   logic [cdc_pkg::fifo_ptr_w-1:0] rd_gray_s1;
   logic [cdc_pkg::fifo_ptr_w-1:0] rd_gray_s2;
   logic [cdc_pkg::fifo_ptr_w-1:0] wr_gap;
   logic                           wr_full;
   logic                           wr_push;
   logic                           wr_ovf;
   logic                           wr_hold;
   logic                           ack_s1;
   logic                           ack_s2;

   // read domain state
   logic [cdc_pkg::fifo_ptr_w-1:0] rd_bin;
   logic [cdc_pkg::fifo_ptr_w-1:0] rd_bin_nxt;
   logic [cdc_pkg::fifo_ptr_w-1:0] rd_gray;
   logic [cdc_pkg::fifo_ptr_w-1:0] wr_gray_s1;
   logic [cdc_pkg::fifo_ptr_w-1:0] wr_gray_s2;
   logic                           flush_s1;
   logic                           rd_flush;
   logic                           ovf_s1;
   logic                           ovf_s2;
   logic                           rd_ovf;
   logic                           rd_udf;
   logic                           rd_req;
   logic                           rd_pop;
   logic                           rd_empty;
   logic                           rd_full;

   function automatic logic [cdc_pkg::fifo_ptr_w-1:0] bin2gray(
      input logic [cdc_pkg::fifo_ptr_w-1:0] b
   );
      return b ^ (b >> 1);
   endfunction

   function automatic logic [cdc_pkg::fifo_ptr_w-1:0] gray2bin(
      input logic [cdc_pkg::fifo_ptr_w-1:0] g
   );
      logic [cdc_pkg::fifo_ptr_w-1:0] b;
      b[cdc_pkg::fifo_ptr_w-1] = g[cdc_pkg::fifo_ptr_w-1];
      for (int i = cdc_pkg::fifo_ptr_w - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // ----------------------------------------------------------
   // write side (camera clock)
   // ----------------------------------------------------------

   assign wr_bin_nxt = wr_bin + 1'b1;

   // full when the pointers differ only in the two top gray bits
   assign wr_full = (wr_gray == {~rd_gray_s2[cdc_pkg::fifo_ptr_w-1:cdc_pkg::fifo_ptr_w-2],
                                 rd_gray_s2[cdc_pkg::fifo_ptr_w-3:0]});

   // camera never stalls so a write while full is simply lost
   assign wr_push = wr_en & ~wr_full & ~wr_flush;

   always_ff @(posedge wr_clk) begin
      if (wr_flush) begin
         wr_bin  <= '0;
         wr_gray <= '0;
         wr_ovf  <= 1'b0;
         wr_hold <= 1'b1;
      end else begin
         // read side has seen the flush and zeroed its pointer
         if (ack_s2) begin
            wr_hold <= 1'b0;
         end
         if (wr_en && wr_full) begin
            wr_ovf <= 1'b1;
         end
         if (wr_push) begin
            wr_bin  <= wr_bin_nxt;
            wr_gray <= bin2gray(wr_bin_nxt);
         end
      end
   end

   always_ff @(posedge wr_clk) begin
      if (wr_push) begin
         mem[wr_bin[cdc_pkg::fifo_ptr_w-2:0]] <= wr_data;
      end
   end

   // read pointer into the write domain
   // parked at zero until the flush has made the round trip
   // so a stale pointer cannot fake a full fifo
   always_ff @(posedge wr_clk) begin
      if (wr_flush || wr_hold) begin
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end else begin
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
      end
   end

   // flush acknowledge back from the read domain
   always_ff @(posedge wr_clk) begin
      ack_s1 <= rd_flush;
      ack_s2 <= ack_s1;
   end

   // ----------------------------------------------------------
   // read side (display clock)
   // ----------------------------------------------------------

   // flush crossing, this pair is the read side reset
   always_ff @(posedge rd_clk) begin
      flush_s1 <= wr_flush;
      rd_flush <= flush_s1;
   end

   assign rd_bin_nxt = rd_bin + 1'b1;
   assign rd_empty   = (rd_gray == wr_gray_s2);
   assign rd_full    = (wr_gray_s2 == {~rd_gray[cdc_pkg::fifo_ptr_w-1:cdc_pkg::fifo_ptr_w-2],
                                       rd_gray[cdc_pkg::fifo_ptr_w-3:0]});

   // display wants a pixel on every active unblanked cycle
   assign rd_req = rd_frame & ~rd_blank;
   assign rd_pop = rd_req & ~rd_empty & ~rd_flush;

   always_ff @(posedge rd_clk) begin
      if (rd_flush) begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
         ovf_s1     <= 1'b0;
         ovf_s2     <= 1'b0;
         rd_ovf     <= 1'b0;
         rd_udf     <= 1'b0;
         rd_valid   <= 1'b0;
      end else begin
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
         // sticky overflow level from the write side
         ovf_s1     <= wr_ovf;
         ovf_s2     <= ovf_s1;
         if (ovf_s2) begin
            rd_ovf <= 1'b1;
         end
         if (rd_req && rd_empty) begin
            rd_udf <= 1'b1;
         end
         rd_valid <= rd_pop;
         if (rd_pop) begin
            rd_bin  <= rd_bin_nxt;
            rd_gray <= bin2gray(rd_bin_nxt);
         end
      end
   end

   // output pixel holds its value on an empty read
   always_ff @(posedge rd_clk) begin
      if (rd_pop) begin
         rd_data <= mem[rd_bin[cdc_pkg::fifo_ptr_w-2:0]];
      end
   end

   always_comb begin
      debug                         = '0;
      debug[cdc_pkg::dbg_full]      = rd_full;
      debug[cdc_pkg::dbg_empty]     = rd_empty;
      debug[cdc_pkg::dbg_overflow]  = rd_ovf;
      debug[cdc_pkg::dbg_underflow] = rd_udf;
   end

   // ----------------------------------------------------------
   // checks
   // ----------------------------------------------------------

   assign wr_gap = wr_bin - gray2bin(rd_gray_s2);

   // writer stays within one fifo depth of the crossed read pointer
   a_wr_ahead : assert property (@(posedge wr_clk) disable iff (wr_flush || wr_hold)
      wr_gap <= cdc_pkg::fifo_depth);

   // a valid pixel always comes from an entry that was written
   a_rd_valid : assert property (@(posedge rd_clk) disable iff (rd_flush)
      rd_valid |-> !$isunknown(rd_data));

endmodule : async_line_fifo

// File: src/camera_to_hdmi_bridge.sv
`timescale 1ns/1ps

module camera_to_hdmi_bridge (
   // ----------------------------------------------------------
   // camera side
   // ----------------------------------------------------------
   input  logic                        csi_clk,
   input  logic                        reset,
   input  logic                        csi_in_frame,
   input  logic                        csi_in_line,
   input  video_pkg::pix_t             rgb_pix,
   input  logic                        rgb_reading,
   output logic                        rgb_valid,

   // ----------------------------------------------------------
   // display side
   // ----------------------------------------------------------
   input  logic                        hdmi_clk,
   input  logic                        hdmi_frame,
   input  logic                        hdmi_blank,
   output logic                        hdmi_reset_n,
   output video_pkg::pix_t             hdmi_pix,
   output logic                        hdmi_pix_valid,
   output logic [cdc_pkg::debug_w-1:0] debug_fifo
);

   // flush request from the tracker into the fifo write side
   logic fifo_flush;

   // frame and line sync in the camera domain
   frame_line_tracker tracker_i (
      .csi_clk      (csi_clk),
      .reset        (reset),
      .csi_in_frame (csi_in_frame),
      .csi_in_line  (csi_in_line),
      .rgb_valid    (rgb_valid),
      .hdmi_reset_n (hdmi_reset_n),
      .fifo_flush   (fifo_flush)
   );

   // line buffer between the camera and display clocks
   // read request is built inside from frame and blank
   async_line_fifo #(
      .payload_t (video_pkg::pix_t)
   ) fifo_i (
      .wr_clk   (csi_clk),
      .wr_flush (fifo_flush),
      .wr_en    (rgb_reading),
      .wr_data  (rgb_pix),
      .rd_clk   (hdmi_clk),
      .rd_frame (hdmi_frame),
      .rd_blank (hdmi_blank),
      .rd_data  (hdmi_pix),
      .rd_valid (hdmi_pix_valid),
      .debug    (debug_fifo)
   );

endmodule : camera_to_hdmi_bridge

// File: bench/bridge_tb.sv
`timescale 1ns/1ps

module bridge_tb;

   localparam int stim_depth   = 64;
   localparam int settle_limit = 40;
   localparam int drain_limit  = 200;

   // clocks start low so the first edge of each is a rising one
   logic csi_clk  = 1'b0;
   logic hdmi_clk = 1'b0;

   logic reset;
   logic csi_in_frame;
   logic csi_in_line;
   video_pkg::pix_t rgb_pix;
   logic rgb_reading;
   logic rgb_valid;
   logic hdmi_frame;
   logic hdmi_blank;
   logic hdmi_reset_n;
   video_pkg::pix_t hdmi_pix;
   logic hdmi_pix_valid;
   logic [cdc_pkg::debug_w-1:0] debug_fifo;

   // stim commands, op in the top nibble
   logic [31:0] stim_mem [stim_depth];

   // scoreboard state
   video_pkg::pix_t pix_q[$];
   video_pkg::pix_t last_pix;
   logic last_seen = 1'b0;
   logic mon_en    = 1'b0;
   logic exp_ovf   = 1'b0;
   logic exp_udf   = 1'b0;
   int line_cnt_model = 0;
   int err_cnt        = 0;

   always #5 csi_clk = ~csi_clk;
   // 7 ns so the two clock phases drift against each other
   always #3.5 hdmi_clk = ~hdmi_clk;

   camera_to_hdmi_bridge dut_i (
      .csi_clk        (csi_clk),
      .reset          (reset),
      .csi_in_frame   (csi_in_frame),
      .csi_in_line    (csi_in_line),
      .rgb_pix        (rgb_pix),
      .rgb_reading    (rgb_reading),
      .rgb_valid      (rgb_valid),
      .hdmi_clk       (hdmi_clk),
      .hdmi_frame     (hdmi_frame),
      .hdmi_blank     (hdmi_blank),
      .hdmi_reset_n   (hdmi_reset_n),
      .hdmi_pix       (hdmi_pix),
      .hdmi_pix_valid (hdmi_pix_valid),
      .debug_fifo     (debug_fifo)
   );

   // ----------------------------------------------------------
   // reporting
   // ----------------------------------------------------------

   task automatic stop_run();
      $display("tests failed");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic report_fail(input string what);
      err_cnt++;
      $display("Error at time %0t: %s", $time, what);
      stop_run();
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         err_cnt++;
         $display("Error at time %0t: %s expected %h got %h", $time, name, exp, got);
         stop_run();
      end
   endtask

   // ----------------------------------------------------------
   // reference model
   // ----------------------------------------------------------

   // debug bus as the fifo rules predict it from the pending pixels
   function automatic logic [cdc_pkg::debug_w-1:0] expected_debug();
      logic [cdc_pkg::debug_w-1:0] d;
      d = '0;
      d[cdc_pkg::dbg_full]      = (pix_q.size() == cdc_pkg::fifo_depth);
      d[cdc_pkg::dbg_empty]     = (pix_q.size() == 0);
      d[cdc_pkg::dbg_overflow]  = exp_ovf;
      d[cdc_pkg::dbg_underflow] = exp_udf;
      return d;
   endfunction

   // writes only happen with the display idle, so fill level is exact
   task automatic write_model(input video_pkg::pix_t p);
      if (pix_q.size() < cdc_pkg::fifo_depth) begin
         pix_q.push_back(p);
      end else begin
         exp_ovf = 1'b1;
      end
   endtask

   // ----------------------------------------------------------
   // camera side driver
   // ----------------------------------------------------------

   task automatic csi_step();
      @(posedge csi_clk);
      #1;
   endtask

   task automatic start_frame();
      if (pix_q.size() != 0) begin
         report_fail("frame start issued while pixels were still pending");
      end
      csi_step();
      csi_in_frame = 1'b0;
      csi_step();
      csi_in_frame = 1'b1;
      repeat (3) csi_step();
      // frame start restarts the count and clears the sticky flags
      line_cnt_model = 0;
      exp_ovf = 1'b0;
      exp_udf = 1'b0;
      @(negedge csi_clk);
      check_eq("rgb_valid", rgb_valid, 1'b0);
      check_eq("hdmi_reset_n", hdmi_reset_n, 1'b0);
   endtask

   // base of zero asks for random pixel values
   task automatic send_line(input int n, input logic [15:0] base);
      video_pkg::pix_t p;
      logic [31:0] rnd;
      csi_step();
      csi_in_line = 1'b0;
      rgb_reading = 1'b0;
      csi_step();
      csi_step();
      csi_in_line = 1'b1;
      for (int i = 0; i < n; i++) begin
         rnd = $urandom;
         if (base == 16'h0000) begin
            p = rnd[23:0];
         end else begin
            p = {base, 8'(i)};
         end
         rgb_pix     = p;
         rgb_reading = 1'b1;
         write_model(p);
         csi_step();
      end
      rgb_reading = 1'b0;
      repeat (3) csi_step();
      if (line_cnt_model < video_pkg::line_cnt_max) begin
         line_cnt_model++;
      end
      // status checked at the line boundary
      @(negedge csi_clk);
      check_eq("rgb_valid", rgb_valid, line_cnt_model >= video_pkg::rgb_valid_line);
      check_eq("hdmi_reset_n", hdmi_reset_n, line_cnt_model >= video_pkg::hdmi_release_line);
   endtask

   // ----------------------------------------------------------
   // display side driver
   // ----------------------------------------------------------

   task automatic hdmi_step();
      @(posedge hdmi_clk);
      #1;
   endtask

   // write pointer must have crossed before reads are predicted
   task automatic settle_empty();
      int n;
      n = 0;
      @(negedge hdmi_clk);
      while ((debug_fifo[cdc_pkg::dbg_empty] !== (pix_q.size() == 0)) && (n < settle_limit)) begin
         @(negedge hdmi_clk);
         n++;
      end
      if (debug_fifo[cdc_pkg::dbg_empty] !== (pix_q.size() == 0)) begin
         report_fail("fifo empty bit did not settle before a read window");
      end
   endtask

   // mask bit k mod 16 set means cycle k is blanked
   task automatic read_window(input int cycles, input logic [15:0] mask);
      int avail;
      logic blank;
      settle_empty();
      avail = pix_q.size();
      for (int k = 0; k < cycles; k++) begin
         blank = mask[k % 16];
         hdmi_step();
         hdmi_frame = 1'b1;
         hdmi_blank = blank;
         if (!blank) begin
            if (avail > 0) begin
               avail--;
            end else begin
               exp_udf = 1'b1;
            end
         end
      end
      hdmi_step();
      hdmi_frame = 1'b0;
      hdmi_blank = 1'b1;
      repeat (3) hdmi_step();
   endtask

   // reads exactly what is pending so no underflow is caused
   task automatic drain_fifo();
      int n;
      settle_empty();
      read_window(pix_q.size(), 16'h0000);
      n = 0;
      while ((pix_q.size() != 0) && (n < drain_limit)) begin
         @(posedge hdmi_clk);
         n++;
      end
      if (pix_q.size() != 0) begin
         report_fail("fifo did not drain, pixels never reached the display");
      end
   endtask

   task automatic check_flags(input logic [cdc_pkg::debug_w-1:0] stim_flags);
      int n;
      n = 0;
      @(negedge hdmi_clk);
      while ((debug_fifo !== expected_debug()) && (n < settle_limit)) begin
         @(negedge hdmi_clk);
         n++;
      end
      check_eq("debug_fifo", debug_fifo, expected_debug());
      check_eq("debug_fifo", debug_fifo, stim_flags);
   endtask

   // ----------------------------------------------------------
   // scoreboard
   // ----------------------------------------------------------

   always @(negedge hdmi_clk) begin
      if (mon_en) begin
         if (hdmi_pix_valid !== 1'b0) begin
            if (pix_q.size() == 0) begin
               report_fail("hdmi_pix_valid high with no pixel pending");
            end else begin
               check_eq("hdmi_pix", hdmi_pix, pix_q.pop_front());
               last_pix  = hdmi_pix;
               last_seen = 1'b1;
            end
         end else if (last_seen) begin
            // pixel holds between reads and on empty reads
            check_eq("hdmi_pix", hdmi_pix, last_pix);
         end
      end
   end

   // ----------------------------------------------------------
   // command sequencer
   // ----------------------------------------------------------

   initial begin
      logic [31:0] word;
      logic done;
      done = 1'b0;
      void'($urandom(32'h0f90_37d3));
      reset        = 1'b1;
      csi_in_frame = 1'b0;
      csi_in_line  = 1'b0;
      rgb_pix      = '0;
      rgb_reading  = 1'b0;
      hdmi_frame   = 1'b0;
      hdmi_blank   = 1'b1;
      $readmemh("bench/bridge_stim.txt", stim_mem);
      repeat (10) @(posedge csi_clk);
      #1;
      reset = 1'b0;
      repeat (4) hdmi_step();
      mon_en = 1'b1;
      @(negedge csi_clk);
      check_eq("rgb_valid", rgb_valid, 1'b0);
      check_eq("hdmi_reset_n", hdmi_reset_n, 1'b0);
      for (int pc = 0; pc < stim_depth; pc++) begin
         word = stim_mem[pc];
         case (word[31:28])
            4'h1: start_frame();
            4'h2: send_line(word[27:16], word[15:0]);
            4'h3: repeat (word[27:16]) send_line(0, 16'h0001);
            4'h4: read_window(word[27:16], word[15:0]);
            4'h5: drain_fifo();
            4'h6: check_flags(word[cdc_pkg::debug_w-1:0]);
            4'hf: done = 1'b1;
            default: report_fail($sformatf("unknown stim command %h at entry %0d", word, pc));
         endcase
         if (done) begin
            break;
         end
      end
      if (!done) begin
         report_fail("stim file ended without an end command");
      end
      if (err_cnt == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         stop_run();
      end
   end

endmodule : bridge_tb

// File: bench/bridge_stim.txt
// one command per line: op[31:28] arg_a[27:16] arg_b[15:0]
// op 1 frame start, 2 line of a pixels (b base, 0 random), 3 a empty lines
// op 4 read window of a cycles with blank mask b, 5 drain, 6 debug check b, f end

// state right after reset, empty only
6_000_0002

// frame a, ordered transfer under gapped and continuous blanking
1_000_0000
6_000_0002
2_006_1234
6_000_0000
// alternate blanked cycles, six reads
4_00C_5555
6_000_0002
// random pixels, then a patterned line
2_005_0000
2_005_ab00
// continuous window takes 8 of 10
4_008_0000
6_000_0000
5_000_0000
6_000_0002

// frame b, line counter runs past its saturation limit
1_000_0000
3_51E_0000
2_004_5a00
5_000_0000
6_000_0002

// frame c, display blanked while 20 pixels arrive
1_000_0000
6_000_0002
2_014_c300
// full and overflow
6_000_0005
5_000_0000
6_000_0006
// unblanked reads on an empty fifo
4_008_0000
6_000_000e

// frame d, new frame clears the sticky flags
1_000_0000
6_000_0002
2_008_0000
// blank on cycles 2, 5, 8 and 11
4_00C_0924
6_000_0002

f_000_0000

// File: tb.f
src/video_pkg.sv
src/cdc_pkg.sv
src/frame_line_tracker.sv
src/async_line_fifo.sv
src/camera_to_hdmi_bridge.sv
bench/bridge_tb.sv

// File: Bender.yml
package:
  name: camera_to_hdmi_bridge

dependencies: {}

sources:
  # packages come first
  - files:
      - src/video_pkg.sv
      - src/cdc_pkg.sv
  # design
  - files:
      - src/frame_line_tracker.sv
      - src/async_line_fifo.sv
      - src/camera_to_hdmi_bridge.sv
  # testbench, top module bridge_tb
  - target: test
    files:
      - bench/bridge_tb.sv
